/* source/ac97_pkg.sv */
package ac97_pkg;

  ////////////////////
  // frame geometry
  ////////////////////

  localparam int BIT_COUNT_W = 8;

  // counter positions within a 256-bit frame
  localparam logic [BIT_COUNT_W-1:0] FRAME_LAST = 8'd255;
  localparam logic [BIT_COUNT_W-1:0] SYNC_LAST  = 8'd15;
  localparam logic [BIT_COUNT_W-1:0] READY_BIT  = 8'd128;

  localparam int SLOT_W = 20;

  // first bit of each outgoing slot
  localparam logic [BIT_COUNT_W-1:0] SLOT1_START = 8'd16;
  localparam logic [BIT_COUNT_W-1:0] SLOT2_START = 8'd36;
  localparam logic [BIT_COUNT_W-1:0] SLOT3_START = 8'd56;
  localparam logic [BIT_COUNT_W-1:0] SLOT4_START = 8'd76;
  // left capture arrives one bit later than slot 3 out
  localparam logic [BIT_COUNT_W-1:0] RX_LEFT_START = 8'd57;

  // user side widths
  localparam int SAMPLE_W = 8;
  localparam int VOLUME_W = 5;
  localparam int SOURCE_W = 3;

  ////////////////////
  // command word
  ////////////////////

  // write view, address plus data
  typedef struct packed {
    logic [7:0]  addr;
    logic [15:0] data;
  } cmd_addr_data_t;

  // read view, msb of the address is the read request
  typedef struct packed {
    logic        read;
    logic [6:0]  index;
    logic [15:0] data;
  } cmd_read_t;

  typedef union packed {
    cmd_addr_data_t ad;
    cmd_read_t      rr;
  } ac97_cmd_t;

  // codec register map
  localparam logic [7:0] REG_VENDOR_ID   = 8'h00;
  localparam logic [7:0] REG_HP_VOL      = 8'h04;
  localparam logic [7:0] REG_BEEP_VOL    = 8'h0A;
  localparam logic [7:0] REG_MIC_VOL     = 8'h0E;
  localparam logic [7:0] REG_PCM_VOL     = 8'h18;
  localparam logic [7:0] REG_REC_SEL     = 8'h1A;
  localparam logic [7:0] REG_REC_GAIN    = 8'h1C;
  localparam logic [7:0] REG_GEN_PURPOSE = 8'h20;

  // fixed register contents
  localparam logic [15:0] PCM_VOL_DATA   = 16'h0808;
  localparam logic [15:0] REC_GAIN_DATA  = 16'h0F0F;
  localparam logic [15:0] MIC_BOOST_DATA = 16'h8048;
  localparam logic [15:0] BEEP_VOL_DATA  = 16'h0000;
  localparam logic [15:0] BYPASS_DATA    = 16'h8000;

endpackage

/* source/frame_timer.sv */
`timescale 1ns/1ns

module frame_timer
  import ac97_pkg::*;
#(
  parameter int RESET_HOLD = 1024
) (
  input  logic                   clk,
  input  logic                   reset,
  output logic [BIT_COUNT_W-1:0] bit_count,
  output logic                   ready,
  output logic                   ac97_synch,
  output logic                   audio_reset_b
);

  // hold counter only needs to reach RESET_HOLD-1
  localparam int HOLD_W = (RESET_HOLD > 1) ? $clog2(RESET_HOLD) : 1;
  localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(RESET_HOLD - 1);

  logic [HOLD_W-1:0] hold_count;

  ////////////////////
  // bit counter
  ////////////////////

  // free running, wraps from 255 to 0
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_count <= '0;
    end else begin
      bit_count <= bit_count + 1'b1;
    end
  end

  // sync rises on the last bit, so it covers counts 0..15
  always_ff @(posedge clk) begin
    if (reset) begin
      ac97_synch <= 1'b0;
    end else if (bit_count == FRAME_LAST) begin
      ac97_synch <= 1'b1;
    end else if (bit_count == SYNC_LAST) begin
      ac97_synch <= 1'b0;
    end
  end

  // one pulse mid frame
  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= (bit_count == READY_BIT);
    end
  end

  ////////////////////
  // codec reset hold
  ////////////////////

  // low for RESET_HOLD cycles, then stays high
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_count    <= '0;
      audio_reset_b <= 1'b0;
    end else if (hold_count == HOLD_LAST) begin
      audio_reset_b <= 1'b1;
    end else begin
      hold_count <= hold_count + 1'b1;
    end
  end

endmodule

/* source/slot_receiver.sv */
`timescale 1ns/1ns

module slot_receiver
  import ac97_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [BIT_COUNT_W-1:0] bit_count,
  input  logic                   ac97_sdata_in,
  output logic [SAMPLE_W-1:0]    audio_in_data
);

  // first count after the left slot has been shifted in
  localparam logic [BIT_COUNT_W-1:0] RX_LEFT_END = RX_LEFT_START + BIT_COUNT_W'(SLOT_W);

  logic [SLOT_W-1:0] rx_shift;
  logic              in_window;

  // counts 57..76 carry the left capture slot
  assign in_window = (bit_count >= RX_LEFT_START) && (bit_count < RX_LEFT_END);

  // msb arrives first
  always_ff @(posedge clk) begin
    if (in_window) begin
      rx_shift <= {rx_shift[SLOT_W-2:0], ac97_sdata_in};
    end
  end

  // take the top bits once the slot is complete, hold for the frame
  always_ff @(posedge clk) begin
    if (reset) begin
      audio_in_data <= '0;
    end else if (bit_count == RX_LEFT_END) begin
      audio_in_data <= rx_shift[SLOT_W-1 -: SAMPLE_W];
    end
  end

endmodule

/* source/command_sequencer.sv */
`timescale 1ns/1ns

module command_sequencer
  import ac97_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                ready,
  input  logic [VOLUME_W-1:0] volume,
  input  logic [SOURCE_W-1:0] source,
  output ac97_cmd_t           cmd,
  output logic                cmd_valid
);

  logic [3:0]          state;
  logic [VOLUME_W-1:0] atten;
  ac97_cmd_t           cmd_next;

  // volume to attenuation, 0 is loudest on the codec
  assign atten = 5'd31 - volume;

  ////////////////////
  // state counter
  ////////////////////

  // one step per frame, wraps after 16
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= '0;
    end else if (ready) begin
      state <= state + 1'b1;
    end
  end

  ////////////////////
  // command table
  ////////////////////

  always_comb begin
    cmd_next = '0;
    case (state)
      4'h3: begin
        // headphone, both channels
        cmd_next.ad.addr = REG_HP_VOL;
        cmd_next.ad.data = {3'b000, atten, 3'b000, atten};
      end
      4'h5: begin
        cmd_next.ad.addr = REG_PCM_VOL;
        cmd_next.ad.data = PCM_VOL_DATA;
      end
      4'h6: begin
        // record source, same on left and right
        cmd_next.ad.addr = REG_REC_SEL;
        cmd_next.ad.data = {5'b00000, source, 5'b00000, source};
      end
      4'h7: begin
        // max record gain
        cmd_next.ad.addr = REG_REC_GAIN;
        cmd_next.ad.data = REC_GAIN_DATA;
      end
      4'h9: begin
        // +20dB mic boost
        cmd_next.ad.addr = REG_MIC_VOL;
        cmd_next.ad.data = MIC_BOOST_DATA;
      end
      4'hA: begin
        cmd_next.ad.addr = REG_BEEP_VOL;
        cmd_next.ad.data = BEEP_VOL_DATA;
      end
      4'hB: begin
        // pcm out bypasses 3D mix
        cmd_next.ad.addr = REG_GEN_PURPOSE;
        cmd_next.ad.data = BYPASS_DATA;
      end
      default: begin
        // vendor id read fills the idle states
        cmd_next.rr.read  = 1'b1;
        cmd_next.rr.index = REG_VENDOR_ID[6:0];
        cmd_next.rr.data  = '0;
      end
    endcase
  end

  // command follows the state by one cycle
  always_ff @(posedge clk) begin
    cmd <= cmd_next;
  end

  // valid from the first pass through state 0 onward
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else if (state == 4'h0) begin
      cmd_valid <= 1'b1;
    end
  end

endmodule

/* source/slot_transmitter.sv */
`timescale 1ns/1ns

module slot_transmitter
  import ac97_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [BIT_COUNT_W-1:0] bit_count,
  input  logic                   ready,
  input  ac97_cmd_t              cmd,
  input  logic                   cmd_valid,
  input  logic [SAMPLE_W-1:0]    audio_out_data,
  output logic                   ac97_sdata_out
);

  // end of slot 4
  localparam logic [BIT_COUNT_W-1:0] SLOT4_END = SLOT4_START + BIT_COUNT_W'(SLOT_W);
  // bit index within one slot
  localparam int IDX_W = $clog2(SLOT_W);

  logic [SAMPLE_W-1:0] held_sample;
  // frame payload left justified in 20-bit slots
  logic [SLOT_W-1:0]   l_slot1;
  logic [SLOT_W-1:0]   l_slot2;
  logic [SLOT_W-1:0]   l_pcm;
  logic                l_cmd_v;
  logic                l_sample_v;
  logic                next_bit;

  // msb of a slot goes out first
  function automatic logic slot_bit(input logic [SLOT_W-1:0]      word,
                                    input logic [BIT_COUNT_W-1:0] offset);
    logic [IDX_W-1:0] idx;
    idx = IDX_W'(BIT_COUNT_W'(SLOT_W - 1) - offset);
    return word[idx];
  endfunction

  // user sample held from the ready pulse
  always_ff @(posedge clk) begin
    if (ready) begin
      held_sample <= audio_out_data;
    end
  end

  ////////////////////
  // frame latch
  ////////////////////

  always_ff @(posedge clk) begin
    if (bit_count == FRAME_LAST) begin
      l_slot1 <= {cmd.ad.addr, 12'h000};
      l_slot2 <= {cmd.ad.data, 4'h0};
      l_pcm   <= {held_sample, {(SLOT_W - SAMPLE_W){1'b0}}};
    end
  end

  // valid flags clear on reset so the first frame is empty
  always_ff @(posedge clk) begin
    if (reset) begin
      l_cmd_v    <= 1'b0;
      l_sample_v <= 1'b0;
    end else if (bit_count == FRAME_LAST) begin
      l_cmd_v    <= cmd_valid;
      l_sample_v <= 1'b1;
    end
  end

  ////////////////////
  // bit select
  ////////////////////

  always_comb begin
    if (bit_count < SLOT1_START) begin
      // slot 0 tags
      case (bit_count[3:0])
        4'h0:    next_bit = 1'b1;
        4'h1:    next_bit = l_cmd_v;
        4'h2:    next_bit = l_cmd_v;
        4'h3:    next_bit = l_sample_v;
        4'h4:    next_bit = l_sample_v;
        default: next_bit = 1'b0;
      endcase
    end else if (bit_count < SLOT2_START) begin
      // command address
      next_bit = l_cmd_v & slot_bit(l_slot1, bit_count - SLOT1_START);
    end else if (bit_count < SLOT3_START) begin
      // command data
      next_bit = l_cmd_v & slot_bit(l_slot2, bit_count - SLOT2_START);
    end else if (bit_count < SLOT4_START) begin
      // left pcm
      next_bit = l_sample_v & slot_bit(l_pcm, bit_count - SLOT3_START);
    end else if (bit_count < SLOT4_END) begin
      // right pcm carries the same sample
      next_bit = l_sample_v & slot_bit(l_pcm, bit_count - SLOT4_START);
    end else begin
      next_bit = 1'b0;
    end
  end

  // bit for count n leaves in the cycle after n
  always_ff @(posedge clk) begin
    if (reset) begin
      ac97_sdata_out <= 1'b0;
    end else begin
      ac97_sdata_out <= next_bit;
    end
  end

endmodule

/* source/ac97_link_top.sv */
`timescale 1ns/1ns

module ac97_link_top
  import ac97_pkg::*;
#(
  parameter int RESET_HOLD = 1024
) (
  input  logic                clk,
  input  logic                reset,
  // user side
  input  logic [VOLUME_W-1:0] volume,
  input  logic [SOURCE_W-1:0] source,
  input  logic [SAMPLE_W-1:0] audio_out_data,
  output logic [SAMPLE_W-1:0] audio_in_data,
  output logic                ready,
  // codec pins
  output logic                audio_reset_b,
  output logic                ac97_sdata_out,
  input  logic                ac97_sdata_in,
  output logic                ac97_synch
);

  logic [BIT_COUNT_W-1:0] bit_count;
  ac97_cmd_t              cmd;
  logic                   cmd_valid;

  ////////////////////
  // frame timing
  ////////////////////

  frame_timer #(
    .RESET_HOLD (RESET_HOLD)
  ) u_frame_timer (
    .clk           (clk),
    .reset         (reset),
    .bit_count     (bit_count),
    .ready         (ready),
    .ac97_synch    (ac97_synch),
    .audio_reset_b (audio_reset_b)
  );

  // capture path
  slot_receiver u_slot_receiver (
    .clk           (clk),
    .reset         (reset),
    .bit_count     (bit_count),
    .ac97_sdata_in (ac97_sdata_in),
    .audio_in_data (audio_in_data)
  );

  // register write table
  command_sequencer u_command_sequencer (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .volume    (volume),
    .source    (source),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  // playback path plus commands
  slot_transmitter u_slot_transmitter (
    .clk            (clk),
    .reset          (reset),
    .bit_count      (bit_count),
    .ready          (ready),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .audio_out_data (audio_out_data),
    .ac97_sdata_out (ac97_sdata_out)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* tb/ac97_link_props.sv */
`timescale 1ns/1ns

module ac97_link_props
  import ac97_pkg::*;
(
  input logic                   clk,
  input logic                   reset,
  input logic [BIT_COUNT_W-1:0] bit_count,
  input logic                   ready,
  input logic                   ac97_synch,
  input logic                   audio_reset_b
);

  // no sync in the frame right after reset
  logic wrapped;

  always_ff @(posedge clk) begin
    if (reset) begin
      wrapped <= 1'b0;
    end else if (bit_count == FRAME_LAST) begin
      wrapped <= 1'b1;
    end
  end

  ////////////////////
  // timer properties
  ////////////////////

  ready_single: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
    else $error("ready high for more than one cycle");

  // high on counts 0..15 once the counter has wrapped
  sync_window: assert property (@(posedge clk) disable iff (reset)
    wrapped |-> (ac97_synch == (bit_count <= SYNC_LAST)))
    else $error("ac97_synch outside counts 0 to 15");

  codec_reset_kept: assert property (@(posedge clk) disable iff (reset)
    $fell(audio_reset_b) |-> $past(reset))
    else $error("audio_reset_b fell without reset");

endmodule

bind frame_timer ac97_link_props u_props (
  .clk           (clk),
  .reset         (reset),
  .bit_count     (bit_count),
  .ready         (ready),
  .ac97_synch    (ac97_synch),
  .audio_reset_b (audio_reset_b)
);

/* tb/tb_ac97_link.sv */
`timescale 1ns/1ns

module tb_ac97_link
  import ac97_pkg::*;
();

  localparam int HOLD         = 1024;
  localparam int FRAME_LEN    = 256;
  localparam int RX_FIRST     = int'(RX_LEFT_START);
  // ready shows one cycle after its count
  localparam int READY_POS    = int'(READY_BIT) + 1;
  // tag slot plus four 20-bit slots
  localparam int TX_BITS      = 96;
  localparam int RX_CHECK_POS = 100;
  localparam int SYNC_TIMEOUT = 2 * FRAME_LEN;
  // frame 0 plus 32 more
  localparam int CHECK_FRAMES = 33;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic                clk;
  logic                reset;
  logic [VOLUME_W-1:0] volume;
  logic [SOURCE_W-1:0] source;
  logic [SAMPLE_W-1:0] audio_out_data;
  logic [SAMPLE_W-1:0] audio_in_data;
  logic                ready;
  logic                audio_reset_b;
  logic                ac97_sdata_out;
  logic                ac97_sdata_in;
  logic                ac97_synch;

  // model and bookkeeping
  logic [31:0]         lfsr;
  int                  cyc;
  int                  ready_cnt;
  int                  frames_done;
  int                  errs [1:5];
  string               names [1:5];
  bit                  timed_out;
  logic                sync_last;
  logic                sync_rose;
  logic                sample_due;
  logic [VOLUME_W-1:0] vol_m;
  logic [SOURCE_W-1:0] src_m;
  logic [SAMPLE_W-1:0] held_sample;
  logic [SAMPLE_W-1:0] lat_sample;
  logic [23:0]         lat_cmd;
  logic                lat_valid;
  logic [SLOT_W-1:0]   cur_word;
  logic [SLOT_W-1:0]   rx_bits;
  logic [TX_BITS-1:0]  frame_bits;

  tb_clock_gen #(.PERIOD(40)) u_clock (.clk(clk));

  ac97_link_top #(
    .RESET_HOLD (HOLD)
  ) UUT (
    .clk            (clk),
    .reset          (reset),
    .volume         (volume),
    .source         (source),
    .audio_out_data (audio_out_data),
    .audio_in_data  (audio_in_data),
    .ready          (ready),
    .audio_reset_b  (audio_reset_b),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch)
  );

  ////////////////////
  // random source
  ////////////////////

  // galois form, shifts right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // register table, indexed by ready pulses seen
  function automatic logic [23:0] expected_cmd(input int st);
    logic [VOLUME_W-1:0] att;
    att = 5'd31 - vol_m;
    case (st)
      3:       return {REG_HP_VOL, 3'b000, att, 3'b000, att};
      5:       return {REG_PCM_VOL, PCM_VOL_DATA};
      6:       return {REG_REC_SEL, 5'b00000, src_m, 5'b00000, src_m};
      7:       return {REG_REC_GAIN, REC_GAIN_DATA};
      9:       return {REG_MIC_VOL, MIC_BOOST_DATA};
      10:      return {REG_BEEP_VOL, BEEP_VOL_DATA};
      11:      return {REG_GEN_PURPOSE, BYPASS_DATA};
      // read flag on top, vendor id index
      default: return {1'b1, REG_VENDOR_ID[6:0], 16'h0000};
    endcase
  endfunction

  task automatic check_value(input int test, input logic [95:0] got,
                             input logic [95:0] exp, input string what);
    if (got !== exp) begin
      errs[test]++;
      $display("ERR at %0t ns: test %0d, %s: got %0h, expected %0h",
               $time, test, what, got, exp);
    end
  endtask

  // decoded frame against the payload latched at the last frame end
  task automatic check_frame();
    logic [15:0] slot0;
    logic [39:0] cmd_slots;
    logic [39:0] pcm_slots;
    slot0     = {1'b1, {4{lat_valid}}, 11'h000};
    cmd_slots = lat_valid ? {lat_cmd[23:16], 12'h000, lat_cmd[15:0], 4'h0} : '0;
    pcm_slots = lat_valid ? {2{lat_sample, 12'h000}} : '0;
    check_value(3, 96'(frame_bits[94:93]), 96'(slot0[14:13]), "command tags");
    check_value(3, 96'(frame_bits[79:40]), 96'(cmd_slots), "command slots");
    check_value(4, 96'({frame_bits[95], frame_bits[92:80]}),
                96'({slot0[15], slot0[12:0]}), "frame and sample tags");
    check_value(4, 96'(frame_bits[39:0]), 96'(pcm_slots), "pcm slots");
    frames_done++;
  endtask

  // codec side view of one cycle, taken at the falling edge
  task automatic observe_cycle();
    int pos;
    pos = cyc % FRAME_LEN;
    sync_rose = ac97_synch && !sync_last;
    sync_last = ac97_synch;
    if (ready) begin
      held_sample = audio_out_data;
      ready_cnt++;
      sample_due = 1'b1;
    end
    // serial out lags the count by one
    if (pos >= 1 && pos <= TX_BITS) begin
      frame_bits = {frame_bits[TX_BITS-2:0], ac97_sdata_out};
    end
    if (pos == TX_BITS) begin
      check_frame();
    end
    if (pos == RX_CHECK_POS) begin
      check_value(5, 96'(audio_in_data), 96'(cur_word[SLOT_W-1 -: SAMPLE_W]),
                  "capture sample");
    end
    // frame end, payload for the next frame
    if (pos == FRAME_LEN - 1) begin
      lat_cmd    = expected_cmd(ready_cnt % 16);
      lat_sample = held_sample;
      lat_valid  = 1'b1;
    end
  endtask

  task automatic step_cycle();
    int          nxt;
    logic [31:0] r;
    @(posedge clk);
    nxt = (cyc + 1) % FRAME_LEN;
    // fresh left capture word each frame, msb first
    if (nxt == RX_FIRST) begin
      take_bits(SLOT_W, r);
      cur_word = SLOT_W'(r);
      rx_bits  = cur_word;
    end
    if (nxt >= RX_FIRST && nxt < RX_FIRST + SLOT_W) begin
      ac97_sdata_in <= rx_bits[SLOT_W-1];
      rx_bits = rx_bits << 1;
    end else begin
      ac97_sdata_in <= 1'b0;
    end
    // previous sample was taken on this edge
    if (sample_due) begin
      take_bits(SAMPLE_W, r);
      audio_out_data <= SAMPLE_W'(r);
      sample_due = 1'b0;
    end
    @(negedge clk);
    cyc++;
    observe_cycle();
  endtask

  task automatic wait_sync_rise();
    int n;
    n = 0;
    while (!sync_rose && n < SYNC_TIMEOUT) begin
      step_cycle();
      n++;
    end
    if (!sync_rose) begin
      $display("timeout: ac97_synch did not rise within %0d cycles", SYNC_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // one frame from a sync rise to the next
  task automatic measure_frame();
    int hi;
    int lo;
    int rdy;
    int n;
    hi  = 0;
    lo  = 0;
    rdy = 0;
    for (n = 0; n < SYNC_TIMEOUT; n++) begin
      if (ac97_synch) hi++;
      else lo++;
      if (ready) begin
        rdy++;
        check_value(2, 96'(cyc % FRAME_LEN), 96'(READY_POS), "ready position");
      end
      step_cycle();
      if (sync_rose) break;
    end
    if (n == SYNC_TIMEOUT) begin
      $display("timeout: no ac97_synch rise ended the frame within %0d cycles", n);
      timed_out = 1'b1;
    end else begin
      check_value(2, 96'(hi), 96'(16), "sync high cycles");
      check_value(2, 96'(lo), 96'(240), "sync low cycles");
      check_value(2, 96'(rdy), 96'(1), "ready pulses per frame");
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %s, %0d errors", t, names[t],
             (errs[t] == 0) ? "ok" : "failed", errs[t]);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    int          t;
    int          n;
    int          failed;
    int          total;
    reset          = 1'b1;
    volume         = '0;
    source         = '0;
    audio_out_data = '0;
    ac97_sdata_in  = 1'b0;
    lfsr           = 32'h8cd585ed;
    names[1] = "reset state";
    names[2] = "frame timing";
    names[3] = "command sequence";
    names[4] = "playback";
    names[5] = "capture";
    for (t = 1; t <= 5; t++) errs[t] = 0;
    {timed_out, sync_last, sync_rose, sample_due, lat_valid} = '0;
    {ready_cnt, frames_done} = '0;
    // settings held for the whole run, first sample before the first ready
    repeat (4) @(posedge clk);
    take_bits(VOLUME_W, r);
    vol_m = VOLUME_W'(r);
    take_bits(SOURCE_W, r);
    src_m = SOURCE_W'(r);
    take_bits(SAMPLE_W, r);
    volume         <= vol_m;
    source         <= src_m;
    audio_out_data <= SAMPLE_W'(r);
    reset          <= 1'b0;
    @(negedge clk);
    cyc = 0;
    // test 1, counter at 0 and codec held in reset
    check_value(1, 96'({ready, ac97_synch, ac97_sdata_out, audio_reset_b}), 96'(0),
                "control outputs after reset");
    check_value(1, 96'(audio_in_data), 96'(0), "audio_in_data after reset");
    while (cyc < HOLD - 1) step_cycle();
    check_value(1, 96'(audio_reset_b), 96'(0), "codec reset before hold ends");
    while (cyc < HOLD + 1) step_cycle();
    check_value(1, 96'(audio_reset_b), 96'(1), "codec reset after hold");
    report_test(1);
    // test 2
    wait_sync_rise();
    for (n = 0; n < 20 && !timed_out; n++) measure_frame();
    if (!timed_out) report_test(2);
    // tests 3 to 5 run in the per cycle model
    n = 0;
    while (!timed_out && frames_done < CHECK_FRAMES && n < CHECK_FRAMES * FRAME_LEN) begin
      step_cycle();
      n++;
    end
    if (!timed_out && frames_done < CHECK_FRAMES) begin
      $display("timeout: only %0d frames decoded", frames_done);
      timed_out = 1'b1;
    end
    if (!timed_out) begin
      for (t = 3; t <= 5; t++) report_test(t);
    end
    failed = 0;
    total  = 0;
    for (t = 1; t <= 5; t++) begin
      total += errs[t];
      if (errs[t] != 0) failed++;
    end
    $display("summary: 5 tests, %0d failed, %0d errors, timeout %0d", failed, total, timed_out);
    if (total == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* list.f */
source/ac97_pkg.sv
source/frame_timer.sv
source/slot_receiver.sv
source/command_sequencer.sv
source/slot_transmitter.sv
source/ac97_link_top.sv
tb/tb_clock_gen.sv
tb/ac97_link_props.sv
tb/tb_ac97_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ac97_link
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove $(OBJ_DIR)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
